//--- hw/mem_port_pkg.sv
package mem_port_pkg;

  localparam int ADDR_W = 32;          // Byte address
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LEN_W  = 8;           // Beats minus one, as on AXI

  // One unit beat request
  // A zero wstrb marks a read, addr and len stay fixed over the burst
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [LEN_W-1:0]  len;
  } burst_req_t;

  // Address phase, shared by AW and AR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } axi_aw_t;

  // Write beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  // Read beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axi_r_t;

  // Bridge runs one burst at a time, writes first
  typedef enum logic [2:0] {
    IDLE,
    WR_ADDR,
    WR_DATA,
    RD_ADDR,
    RD_DATA
  } bridge_state_e;

endpackage

//--- hw/bus_merge.sv
module bus_merge #(
  parameter int N_PORTS = 3
) (
  input  logic                            clk,
  input  logic                            rst,

  // Unit side
  input  logic [N_PORTS-1:0]              s_valid,
  input  mem_port_pkg::burst_req_t        s_req [N_PORTS],
  output logic [N_PORTS-1:0]              s_ready,
  output logic [N_PORTS-1:0]              s_last,
  output logic [mem_port_pkg::DATA_W-1:0] s_rdata,

  // Merged write channel
  output logic                            w_valid,
  output mem_port_pkg::burst_req_t        w_req,
  input  logic                            w_ready,
  input  logic                            w_last,

  // Merged read channel
  output logic                            r_valid,
  output mem_port_pkg::axi_aw_t           r_addr,
  input  logic                            r_ready,
  input  logic                            r_last,
  input  logic [mem_port_pkg::DATA_W-1:0] r_data
);
  import mem_port_pkg::*;

  localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  logic             w_running;   // Write direction busy
  logic [IDX_W-1:0] w_idx;
  logic             r_running;   // Read direction busy
  logic [IDX_W-1:0] r_idx;

  logic             w_pend;
  logic [IDX_W-1:0] w_pick;
  logic             r_pend;
  logic [IDX_W-1:0] r_pick;
  burst_req_t       r_sel;

  // Later ports overwrite earlier ones, so the highest index wins
  always_comb begin
    w_pend = 1'b0;
    w_pick = '0;
    r_pend = 1'b0;
    r_pick = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (s_valid[i]) begin
        if (|s_req[i].wstrb) begin
          w_pend = 1'b1;
          w_pick = IDX_W'(i);
        end else begin
          r_pend = 1'b1;
          r_pick = IDX_W'(i);
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_running <= 1'b0;
      w_idx     <= '0;
      r_running <= 1'b0;
      r_idx     <= '0;
    end else begin
      if (!w_running && w_pend) begin
        w_running <= 1'b1;
        w_idx     <= w_pick;
      end else if (w_running && w_valid && w_ready && w_last) begin
        w_running <= 1'b0;     // Free again next cycle
      end

      if (!r_running && r_pend) begin
        r_running <= 1'b1;
        r_idx     <= r_pick;
      end else if (r_running && r_valid && r_ready && r_last) begin
        r_running <= 1'b0;
      end
    end
  end

  assign r_sel   = s_req[r_idx];

  assign w_valid = w_running && s_valid[w_idx];
  assign w_req   = s_req[w_idx];
  assign r_valid = r_running && s_valid[r_idx];
  assign r_addr  = '{addr: r_sel.addr, len: r_sel.len};
  assign s_rdata = r_data;     // Shared by all units

  // Ready and last only go back to the unit holding the grant
  always_comb begin
    for (int i = 0; i < N_PORTS; i++) begin
      s_ready[i] = (w_running && (w_idx == IDX_W'(i)) && w_ready) ||
                   (r_running && (r_idx == IDX_W'(i)) && r_ready);
      s_last[i]  = (w_running && (w_idx == IDX_W'(i)) && w_ready && w_last) ||
                   (r_running && (r_idx == IDX_W'(i)) && r_ready && r_last);
    end
  end

  // Units must keep valid up for the whole granted burst
  a_w_grant_valid: assert property (@(posedge clk) disable iff (rst)
    w_running |-> s_valid[w_idx])
    else $error("write grant on port %0d without valid", w_idx);

  a_r_grant_valid: assert property (@(posedge clk) disable iff (rst)
    r_running |-> s_valid[r_idx])
    else $error("read grant on port %0d without valid", r_idx);

endmodule

//--- hw/axi_burst_bridge.sv
module axi_burst_bridge (
  input  logic                            clk,
  input  logic                            rst,

  // Merge side, write
  input  logic                            w_valid,
  input  mem_port_pkg::burst_req_t        w_req,
  output logic                            w_ready,
  output logic                            w_last,

  // Merge side, read
  input  logic                            r_valid,
  input  mem_port_pkg::axi_aw_t           r_addr,
  output logic                            r_ready,
  output logic                            r_last,
  output logic [mem_port_pkg::DATA_W-1:0] r_data,

  // AXI write address and data
  output mem_port_pkg::axi_aw_t           aw,
  output logic                            awvalid,
  input  logic                            awready,
  output mem_port_pkg::axi_w_t            w,
  output logic                            wvalid,
  input  logic                            wready,

  // AXI read address and data
  output mem_port_pkg::axi_aw_t           ar,
  output logic                            arvalid,
  input  logic                            arready,
  input  mem_port_pkg::axi_r_t            r,
  input  logic                            rvalid,
  output logic                            rready,

  output logic                            bready
);
  import mem_port_pkg::*;

  bridge_state_e    state;
  logic [LEN_W-1:0] beat_cnt;    // Write beats already passed
  logic             beat_last;
  logic             w_fire;
  logic             r_fire;

  assign w_fire    = wvalid && wready;
  assign r_fire    = rvalid && rready;
  assign beat_last = (beat_cnt == w_req.len);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          beat_cnt <= '0;
          if (w_valid) begin
            state <= WR_ADDR;  // Writes win over reads
          end else if (r_valid) begin
            state <= RD_ADDR;
          end
        end
        WR_ADDR: begin
          if (awready) begin
            state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            if (beat_last) begin
              state    <= IDLE;
              beat_cnt <= '0;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        RD_ADDR: begin
          if (arready) begin
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          // Memory marks the end of the read burst
          if (r_fire && r.last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address phases, INCR bursts of full words
  assign awvalid = (state == WR_ADDR);
  assign aw      = '{addr: w_req.addr, len: w_req.len};
  assign arvalid = (state == RD_ADDR);
  assign ar      = r_addr;

  // Write beats pass straight through from the granted unit
  assign wvalid  = (state == WR_DATA) && w_valid;
  assign w       = '{data: w_req.wdata, strb: w_req.wstrb, last: beat_last};
  assign w_ready = (state == WR_DATA) && w_valid && wready;
  assign w_last  = (state == WR_DATA) && beat_last;

  // Read beats only taken while the unit is waiting
  assign rready  = (state == RD_DATA) && r_valid;
  assign r_ready = (state == RD_DATA) && r_valid && rvalid;
  assign r_last  = (state == RD_DATA) && r.last;
  assign r_data  = r.data;

  assign bready  = 1'b1;       // Write responses are dropped

  // Address must hold, including the unit's addr and len, until accepted
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(aw))
    else $error("AW changed before awready");

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("AR changed before arready");

  a_one_addr: assert property (@(posedge clk) disable iff (rst)
    !(awvalid && arvalid))
    else $error("AW and AR valid together");

endmodule

//--- hw/skid_buffer.sv
module skid_buffer (
  input  logic                 clk,
  input  logic                 rst,

  // From the memory
  input  logic                 in_valid,
  output logic                 in_ready,
  input  mem_port_pkg::axi_r_t in_data,

  // Toward the bridge
  output logic                 out_valid,
  input  logic                 out_ready,
  output mem_port_pkg::axi_r_t out_data
);
  import mem_port_pkg::*;

  axi_r_t spare_q;             // Beat caught during a stall
  logic   spare_full;
  logic   in_fire;

  assign in_fire = in_valid && in_ready;

  // in_ready is a flop, so the stall reaches the memory one cycle late
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      spare_full <= 1'b0;
      in_ready   <= 1'b1;
    end else if (spare_full) begin
      if (out_ready) begin
        spare_full <= 1'b0;    // Drained, open the input again
        in_ready   <= 1'b1;
      end
    end else if (in_fire && !out_ready) begin
      spare_full <= 1'b1;
      in_ready   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!spare_full && in_fire && !out_ready) begin
      spare_q <= in_data;
    end
  end

  // Pass-through unless a beat is parked
  assign out_valid = spare_full || in_valid;
  assign out_data  = spare_full ? spare_q : in_data;

  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    spare_full |-> !in_fire)
    else $error("R beat accepted while spare register full");

endmodule

//--- hw/mem_port_top.sv
module mem_port_top #(
  parameter int N_PORTS = 3
) (
  input  logic                            clk,
  input  logic                            rst,

  // Unit ports
  input  logic [N_PORTS-1:0]              valid,
  input  mem_port_pkg::burst_req_t        req [N_PORTS],
  output logic [N_PORTS-1:0]              ready,
  output logic [N_PORTS-1:0]              last,
  output logic [mem_port_pkg::DATA_W-1:0] rdata,

  // AXI master
  output mem_port_pkg::axi_aw_t           aw,
  output logic                            awvalid,
  input  logic                            awready,
  output mem_port_pkg::axi_w_t            w,
  output logic                            wvalid,
  input  logic                            wready,
  output mem_port_pkg::axi_aw_t           ar,
  output logic                            arvalid,
  input  logic                            arready,
  input  mem_port_pkg::axi_r_t            r,
  input  logic                            rvalid,
  output logic                            rready,
  input  logic                            bvalid,
  output logic                            bready
);
  import mem_port_pkg::*;

  // Merged channels between merge and bridge
  logic              mw_valid;
  burst_req_t        mw_req;
  logic              mw_ready;
  logic              mw_last;
  logic              mr_valid;
  axi_aw_t           mr_addr;
  logic              mr_ready;
  logic              mr_last;
  logic [DATA_W-1:0] mr_data;

  // Registered R channel into the bridge
  axi_r_t            sk_r;
  logic              sk_rvalid;
  logic              sk_rready;

  bus_merge #(
    .N_PORTS (N_PORTS)
  ) merge_i (
    .clk     (clk),
    .rst     (rst),
    .s_valid (valid),
    .s_req   (req),
    .s_ready (ready),
    .s_last  (last),
    .s_rdata (rdata),
    .w_valid (mw_valid),
    .w_req   (mw_req),
    .w_ready (mw_ready),
    .w_last  (mw_last),
    .r_valid (mr_valid),
    .r_addr  (mr_addr),
    .r_ready (mr_ready),
    .r_last  (mr_last),
    .r_data  (mr_data)
  );

  axi_burst_bridge bridge_i (
    .clk     (clk),
    .rst     (rst),
    .w_valid (mw_valid),
    .w_req   (mw_req),
    .w_ready (mw_ready),
    .w_last  (mw_last),
    .r_valid (mr_valid),
    .r_addr  (mr_addr),
    .r_ready (mr_ready),
    .r_last  (mr_last),
    .r_data  (mr_data),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .r       (sk_r),
    .rvalid  (sk_rvalid),
    .rready  (sk_rready),
    .bready  (bready)
  );

  skid_buffer r_skid_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rvalid),
    .in_ready  (rready),
    .in_data   (r),
    .out_valid (sk_rvalid),
    .out_ready (sk_rready),
    .out_data  (sk_r)
  );

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;               // Released with the other inputs
  end

endmodule

//--- tests/tb_axi_mem.sv
module tb_axi_mem #(
  parameter int WORDS = 1024
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [3:0]            stall,   // AW, W, AR, R from bit 0 up

  input  mem_port_pkg::axi_aw_t aw,
  input  logic                  awvalid,
  output logic                  awready,
  input  mem_port_pkg::axi_w_t  w,
  input  logic                  wvalid,
  output logic                  wready,
  input  mem_port_pkg::axi_aw_t ar,
  input  logic                  arvalid,
  output logic                  arready,
  output mem_port_pkg::axi_r_t  r,
  output logic                  rvalid,
  input  logic                  rready,
  output logic                  bvalid,
  input  logic                  bready
);
  import mem_port_pkg::*;

  localparam int IDX_W = $clog2(WORDS);

  logic [DATA_W-1:0] mem [WORDS];
  logic              w_busy;     // AW taken, beats still to come
  logic [IDX_W-1:0]  w_ptr;
  logic              r_busy;
  logic [IDX_W-1:0]  r_ptr;
  logic [LEN_W-1:0]  r_left;     // Read beats left after the current one

  // Fill pattern built from the whole word index
  initial begin
    for (int k = 0; k < WORDS; k++) begin
      mem[k] = 32'hc0de_0000 ^ (32'(k) * 32'h0001_0101);
    end
  end

  // One burst per direction at a time
  assign awready = !w_busy && !stall[0];
  assign wready  = w_busy && !stall[1];
  assign arready = !r_busy && !stall[2];
  assign rvalid  = r_busy && !stall[3];
  assign r       = '{data: mem[r_ptr], last: (r_left == '0)};

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      w_busy <= 1'b0;
      w_ptr  <= '0;
      bvalid <= 1'b0;
    end else begin
      bvalid <= 1'b0;            // bready is always high on this bus
      if (awvalid && awready) begin
        w_busy <= 1'b1;
        w_ptr  <= aw.addr[IDX_W+1:2];
      end else if (wvalid && wready) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (w.strb[b]) begin
            mem[w_ptr][8*b +: 8] <= w.data[8*b +: 8];
          end
        end
        w_ptr <= w_ptr + IDX_W'(1);
        if (w.last) begin
          w_busy <= 1'b0;
          bvalid <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      r_busy <= 1'b0;
      r_ptr  <= '0;
      r_left <= '0;
    end else if (arvalid && arready) begin
      r_busy <= 1'b1;
      r_ptr  <= ar.addr[IDX_W+1:2];
      r_left <= ar.len;
    end else if (rvalid && rready) begin
      r_ptr <= r_ptr + IDX_W'(1);  // INCR burst
      if (r_left == '0) begin
        r_busy <= 1'b0;
      end else begin
        r_left <= r_left - LEN_W'(1);
      end
    end
  end

endmodule

//--- tests/tb_top.sv
module tb_top;
  import mem_port_pkg::*;

  localparam int N_PORTS    = 3;
  localparam int WORDS      = 1024;
  localparam int CLK_PERIOD = 20;
  localparam int DRV_DLY    = 2;
  localparam int N_BURSTS   = 15;
  localparam int WATCHDOG_CYCLES = 200 * N_BURSTS + 1000;
  localparam logic [31:0] SEED   = 32'h9f33;

  logic                clk;
  logic                rst;
  logic [N_PORTS-1:0]  valid;
  burst_req_t          req [N_PORTS];
  logic [N_PORTS-1:0]  ready;
  logic [N_PORTS-1:0]  last;
  logic [DATA_W-1:0]   rdata;
  axi_aw_t             aw;
  axi_aw_t             ar;
  axi_w_t              w;
  axi_r_t              r;
  logic                awvalid, awready, wvalid, wready, arvalid, arready;
  logic                rvalid, rready, bvalid, bready;
  logic [3:0]          stall = '0;
  logic [3:0]          stall_bits;
  bit                  stall_en = 1'b0;

  logic [31:0]         data_lfsr  = SEED;
  logic [31:0]         stall_lfsr = SEED;
  logic [31:0]         shadow [WORDS];     // Expected memory contents
  logic [31:0]         wdata_q [N_PORTS][16];
  logic [3:0]          wstrb_q [N_PORTS][16];
  int                  beat_no [N_PORTS];
  logic [31:0]         aw_log [$];         // AW addresses in order of acceptance
  int                  checks = 0;
  int                  errors = 0;

  tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(5)) clock_i (.clk(clk), .rst(rst));

  mem_port_top #(.N_PORTS(N_PORTS)) dut_i (
    .clk(clk), .rst(rst),
    .valid(valid), .req(req), .ready(ready), .last(last), .rdata(rdata),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .rready(rready),
    .bvalid(bvalid), .bready(bready)
  );

  tb_axi_mem #(.WORDS(WORDS)) mem_i (
    .clk(clk), .rst(rst), .stall(stall),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .rready(rready),
    .bvalid(bvalid), .bready(bready)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      data_lfsr = lfsr_step(data_lfsr);
      val = {val[30:0], data_lfsr[0]};
    end
  endtask

  function automatic logic [31:0] fill_word(input int k);
    return 32'hc0de_0000 ^ (32'(k) * 32'h0001_0101);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // Expected read data of an INCR burst at beat k
  function automatic logic [31:0] ref_read(input logic [31:0] addr, input int k);
    return shadow[(int'(addr >> 2) + k) % WORDS];
  endfunction

  task automatic write_shadow(input logic [31:0] addr, input int k,
                              input logic [31:0] data, input logic [3:0] strb);
    int idx;
    idx = (int'(addr >> 2) + k) % WORDS;
    shadow[idx] = merge_bytes(shadow[idx], data, strb);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  // AW carries the address and length of a write burst some unit is holding
  task automatic check_aw();
    bit found;
    found = 1'b0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (valid[i] && |req[i].wstrb && req[i].addr == aw.addr) begin
        found = 1'b1;
        check_value("aw.len", 32'(req[i].len), 32'(aw.len));
      end
    end
    if (!found) report_failure("AW address matches no pending write burst");
  endtask

  // Data and strobes of a write burst, drawn before any burst starts
  task automatic prepare_write(input int port, input int len, input bit partial);
    logic [31:0] val;
    for (int k = 0; k <= len; k++) begin
      draw_bits(32, val);
      wdata_q[port][k] = val;
      wstrb_q[port][k] = 4'hf;
      if (partial) begin
        draw_bits(4, val);
        wstrb_q[port][k] = (val[3:0] == 4'h0) ? 4'b0100 : val[3:0];  // Zero would mean read
      end
    end
  endtask

  // Plays one unit, holding valid until len+1 beats have passed
  task automatic run_burst(input int port, input logic [31:0] addr, input int len,
                           input bit is_write);
    int k;
    bit fire;
    k = 0;
    @(posedge clk);
    #DRV_DLY;
    req[port].addr  = addr;
    req[port].len   = LEN_W'(len);
    req[port].wdata = is_write ? wdata_q[port][0] : '0;
    req[port].wstrb = is_write ? wstrb_q[port][0] : '0;
    valid[port]     = 1'b1;
    while (k <= len) begin
      @(negedge clk);
      fire = ready[port];
      @(posedge clk);
      #DRV_DLY;
      if (fire) begin
        k++;
        if (is_write && k <= len) begin
          req[port].wdata = wdata_q[port][k];
          req[port].wstrb = wstrb_q[port][k];
        end
      end
    end
    valid[port]     = 1'b0;
    req[port].wstrb = '0;
  endtask

  // One stall bit per AXI channel and cycle
  always @(posedge clk) begin
    #DRV_DLY;
    if (stall_en) begin
      for (int b = 0; b < 4; b++) begin
        stall_lfsr    = lfsr_step(stall_lfsr);
        stall_bits[b] = stall_lfsr[0];
      end
      stall = stall_bits;
    end else begin
      stall = 4'b0000;
    end
  end

  // Compares every unit transfer against the shadow memory
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (awvalid && awready) begin
        aw_log.push_back(aw.addr);
        check_aw();
      end
      if (bvalid) check_value("bready", 32'd1, 32'(bready));
      for (int i = 0; i < N_PORTS; i++) begin
        if (ready[i] && !valid[i]) begin
          report_failure($sformatf("port %0d got ready without a request", i));
        end else if (ready[i]) begin
          if (|req[i].wstrb) begin
            write_shadow(req[i].addr, beat_no[i], req[i].wdata, req[i].wstrb);
          end else begin
            check_value($sformatf("rdata port %0d", i), ref_read(req[i].addr, beat_no[i]),
                        rdata);
          end
          if (beat_no[i] == int'(req[i].len)) begin
            if (!last[i]) report_failure($sformatf("port %0d final beat had no last", i));
            beat_no[i] = 0;
          end else begin
            check_value($sformatf("last[%0d]", i), 32'd0, 32'(last[i]));
            beat_no[i]++;
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Summary: %0d checks, %0d errors", checks, errors + 1);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    valid = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      req[i]     = '0;
      beat_no[i] = 0;
    end
    for (int k = 0; k < WORDS; k++) shadow[k] = fill_word(k);
    wait (rst === 1'b0);

    // Full write and read back on port 0
    prepare_write(0, 3, 1'b0);
    run_burst(0, 32'h100, 3, 1'b1);
    run_burst(0, 32'h100, 3, 1'b0);

    // Partial strobes over the same words
    prepare_write(0, 3, 1'b1);
    run_burst(0, 32'h100, 3, 1'b1);
    run_burst(0, 32'h100, 3, 1'b0);

    // Same-cycle writes, port 2 must win
    prepare_write(1, 3, 1'b0);
    prepare_write(2, 3, 1'b0);
    aw_log.delete();
    fork
      run_burst(1, 32'h300, 3, 1'b1);
      run_burst(2, 32'h400, 3, 1'b1);
    join
    if (aw_log.size() < 2) begin
      report_failure("fewer than two AW bursts after two write requests");
    end else begin
      check_value("aw.addr first", 32'h400, aw_log[0]);
      check_value("aw.addr second", 32'h300, aw_log[1]);
    end
    fork
      run_burst(1, 32'h300, 3, 1'b0);
      run_burst(2, 32'h400, 3, 1'b0);
    join

    // Long bursts with stalls on all channels
    prepare_write(0, 15, 1'b0);
    prepare_write(1, 15, 1'b0);
    stall_en = 1'b1;
    fork
      run_burst(0, 32'h500, 15, 1'b1);
      run_burst(1, 32'h600, 15, 1'b1);
    join
    fork
      run_burst(2, 32'h500, 15, 1'b0);
      run_burst(0, 32'h600, 15, 1'b0);
    join
    stall_en = 1'b0;

    // Write and read of separate regions at once
    prepare_write(0, 7, 1'b0);
    fork
      run_burst(0, 32'h700, 7, 1'b1);
      run_burst(1, 32'h800, 7, 1'b0);
    join
    run_burst(1, 32'h700, 7, 1'b0);

    repeat (4) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
hw/mem_port_pkg.sv
hw/bus_merge.sv
hw/axi_burst_bridge.sv
hw/skid_buffer.sv
hw/mem_port_top.sv
tests/tb_clock.sv
tests/tb_axi_mem.sv
tests/tb_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_top --Mdir obj_dir
	./obj_dir/Vtb_top | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
